/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_subsys
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

/* design/bus_pkg.sv */
// cache-side strobes; one word per transfer, no burst or error fields
`include "mem_defs.svh"

package bus_pkg;

  typedef enum logic [2:0] {
    NONE,
    IFETCH,
    DREAD,
    DREADX,  // read for ownership
    DWRITE
  } req_kind_t;

  // request strobe from a cache
  typedef struct packed {
    logic                   valid;
    req_kind_t              kind;
    logic [`MEM_WORD_W-1:0] addr;
    logic [`MEM_WORD_W-1:0] data;  // DWRITE only
  } cpu_req_t;

  typedef struct packed {
    logic                   valid;
    logic                   is_instr;
    logic [`MEM_WORD_W-1:0] data;  // zero for a write
  } cpu_rsp_t;

  // controller to the non-requesting cache
  typedef struct packed {
    logic                   valid;
    logic [`MEM_WORD_W-1:0] addr;
    logic                   inv;
  } snoop_t;

  typedef struct packed {
    logic                   valid;
    logic                   dirty;
    logic [`MEM_WORD_W-1:0] data;
  } snoop_rsp_t;

  // one instruction slot and one data slot per port
  typedef struct packed {
    logic                   ivalid;
    logic [`MEM_WORD_W-1:0] iaddr;
    logic                   dvalid;
    req_kind_t              dkind;
    logic [`MEM_WORD_W-1:0] daddr;
    logic [`MEM_WORD_W-1:0] ddata;
  } port_pend_t;

endpackage

/* design/coherence_ctrl.sv */
// two-cpu arbiter with snooping; a snoop answer is awaited indefinitely, no timeout
`timescale 1ns/1ns
`include "mem_defs.svh"

module coherence_ctrl
  import bus_pkg::*;
  import ram_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  port_pend_t             pend [`MEM_CPUS],
  input  snoop_rsp_t             snoop_rsp [`MEM_CPUS],
  input  ram_state_t             ram_state,
  input  logic [`MEM_WORD_W-1:0] ram_load,
  output logic [`MEM_CPUS-1:0]   grant_i,
  output logic [`MEM_CPUS-1:0]   grant_d,
  output cpu_rsp_t               rsp [`MEM_CPUS],
  output snoop_t                 snoop [`MEM_CPUS],
  output ram_cmd_t               ram_cmd
);

  typedef enum logic [2:0] {IDLE, WRITE, SNOOP, SNOOP_WB, LOAD, IFETCH} state_t;

  state_t                 state, nxt_state;
  logic                   svc, nxt_svc;  // cpu being served
  logic                   lru, nxt_lru;  // cpu owed the next fetch
  logic                   snoop_go, nxt_snoop_go;
  logic [`MEM_WORD_W-1:0] snoop_addr, nxt_snoop_addr;
  logic                   snoop_inv, nxt_snoop_inv;
  logic [`MEM_WORD_W-1:0] wb_data, nxt_wb_data;  // dirty word from the other cache
  logic                   d_found;
  logic                   other;
  logic                   ram_done;

  assign other    = ~svc;  // two cpus only
  assign ram_done = (ram_state == ACCESS);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state    <= IDLE;
      svc      <= 1'b0;
      lru      <= 1'b0;  // cpu 0 first
      snoop_go <= 1'b0;
    end
    else
    begin
      state    <= nxt_state;
      svc      <= nxt_svc;
      lru      <= nxt_lru;
      snoop_go <= nxt_snoop_go;
    end
  end

  always_ff @(posedge CLK)
  begin
    snoop_addr <= nxt_snoop_addr;
    snoop_inv  <= nxt_snoop_inv;
    wb_data    <= nxt_wb_data;
  end

  // snoop strobe in the first SNOOP cycle, to the other cache only
  always_comb
  begin
    for (int c = 0; c < `MEM_CPUS; c++)
    begin
      snoop[c].valid = snoop_go && (1'(c) == other);
      snoop[c].addr  = snoop_addr;
      snoop[c].inv   = snoop_inv;
    end
  end

  always_comb
  begin
    nxt_state      = state;
    nxt_svc        = svc;
    nxt_lru        = lru;
    nxt_snoop_go   = 1'b0;
    nxt_snoop_addr = snoop_addr;
    nxt_snoop_inv  = snoop_inv;
    nxt_wb_data    = wb_data;
    d_found        = 1'b0;
    ram_cmd        = '0;
    grant_i        = '0;
    grant_d        = '0;
    for (int c = 0; c < `MEM_CPUS; c++)
      rsp[c] = '0;

    case (state)
      IDLE:
      begin
        // lower cpu index wins; a port holds one data request, so wb and read never clash
        for (int c = 0; c < `MEM_CPUS; c++)
        begin
          if (!d_found && pend[c].dvalid)
          begin
            d_found = 1'b1;
            nxt_svc = 1'(c);
            if (pend[c].dkind == DWRITE)
              nxt_state = WRITE;
            else
            begin
              nxt_state      = SNOOP;
              nxt_snoop_go   = 1'b1;
              nxt_snoop_addr = pend[c].daddr;
              nxt_snoop_inv  = (pend[c].dkind == DREADX);
            end
          end
        end
        if (!d_found && (pend[0].ivalid || pend[1].ivalid))
        begin
          if (pend[0].ivalid && pend[1].ivalid)
            nxt_svc = lru;
          else
            nxt_svc = pend[1].ivalid;
          nxt_lru   = ~nxt_svc;  // other cpu goes next
          nxt_state = IFETCH;
        end
      end

      WRITE:
      begin
        ram_cmd.wen   = 1'b1;
        ram_cmd.addr  = pend[svc].daddr;
        ram_cmd.store = pend[svc].ddata;
        if (ram_done)
        begin
          rsp[svc].valid = 1'b1;
          grant_d[svc]   = 1'b1;
          nxt_state      = IDLE;
        end
      end

      SNOOP:
      begin
        if (snoop_rsp[other].valid)
        begin
          nxt_wb_data = snoop_rsp[other].data;
          nxt_state   = snoop_rsp[other].dirty ? SNOOP_WB : LOAD;
        end
      end

      SNOOP_WB:
      begin
        // write the dirty line back and hand it over at once
        ram_cmd.wen   = 1'b1;
        ram_cmd.addr  = snoop_addr;
        ram_cmd.store = wb_data;
        if (ram_done)
        begin
          rsp[svc].valid = 1'b1;
          rsp[svc].data  = wb_data;
          grant_d[svc]   = 1'b1;
          nxt_state      = IDLE;
        end
      end

      LOAD:
      begin
        ram_cmd.ren  = 1'b1;
        ram_cmd.addr = snoop_addr;
        if (ram_done)
        begin
          rsp[svc].valid = 1'b1;
          rsp[svc].data  = ram_load;
          grant_d[svc]   = 1'b1;
          nxt_state      = IDLE;
        end
      end

      IFETCH:
      begin
        ram_cmd.ren  = 1'b1;
        ram_cmd.addr = pend[svc].iaddr;
        if (ram_done)
        begin
          rsp[svc].valid    = 1'b1;
          rsp[svc].is_instr = 1'b1;
          rsp[svc].data     = ram_load;
          grant_i[svc]      = 1'b1;
          nxt_state         = IDLE;
        end
      end

      default: nxt_state = IDLE;
    endcase
  end

endmodule

/* design/cpu_port.sv */
// holds one fetch and one data request; a strobe into a full slot is dropped, not queued
`timescale 1ns/1ns
`include "mem_defs.svh"

module cpu_port
  import bus_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  cpu_req_t   req,
  input  logic       grant_i,
  input  logic       grant_d,
  output port_pend_t pend
);

  logic                   ivalid;
  logic [`MEM_WORD_W-1:0] iaddr;
  logic                   dvalid;
  req_kind_t              dkind;
  logic [`MEM_WORD_W-1:0] daddr;
  logic [`MEM_WORD_W-1:0] ddata;
  logic                   take_i;
  logic                   take_d;

  // NONE falls through both
  assign take_i = req.valid && (req.kind == IFETCH) && !ivalid;
  assign take_d = req.valid && (req.kind inside {DREAD, DREADX, DWRITE}) && !dvalid;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      ivalid <= 1'b0;
      dvalid <= 1'b0;
    end
    else
    begin
      if (grant_i)
        ivalid <= 1'b0;  // served this cycle
      else if (take_i)
        ivalid <= 1'b1;
      if (grant_d)
        dvalid <= 1'b0;
      else if (take_d)
        dvalid <= 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (take_i)
      iaddr <= req.addr;
    if (take_d)
    begin
      dkind <= req.kind;
      daddr <= req.addr;
      ddata <= req.data;
    end
  end

  assign pend = '{ivalid: ivalid, iaddr: iaddr,
                  dvalid: dvalid, dkind: dkind, daddr: daddr, ddata: ddata};

endmodule

/* design/mem_subsys_top.sv */
// shared-memory side for MEM_CPUS caches; caches are external and answer every snoop
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_subsys_top
  import bus_pkg::*;
  import ram_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  cpu_req_t   req [`MEM_CPUS],
  input  snoop_rsp_t snoop_rsp [`MEM_CPUS],
  output cpu_rsp_t   rsp [`MEM_CPUS],
  output snoop_t     snoop [`MEM_CPUS]
);

  port_pend_t             pend [`MEM_CPUS];
  logic [`MEM_CPUS-1:0]   grant_i;
  logic [`MEM_CPUS-1:0]   grant_d;
  ram_cmd_t               ram_cmd;
  ram_state_t             ram_state;
  logic [`MEM_WORD_W-1:0] ram_load;

  // one request holder per cpu
  generate
    for (genvar c = 0; c < `MEM_CPUS; c++)
    begin : g_port
      cpu_port u_cpu_port (
        .CLK     (CLK),
        .nRST    (nRST),
        .req     (req[c]),
        .grant_i (grant_i[c]),
        .grant_d (grant_d[c]),
        .pend    (pend[c])
      );
    end
  endgenerate

  coherence_ctrl u_coherence_ctrl (
    .CLK       (CLK),
    .nRST      (nRST),
    .pend      (pend),
    .snoop_rsp (snoop_rsp),
    .ram_state (ram_state),
    .ram_load  (ram_load),
    .grant_i   (grant_i),
    .grant_d   (grant_d),
    .rsp       (rsp),
    .snoop     (snoop),
    .ram_cmd   (ram_cmd)
  );

  ram_model u_ram_model (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_cmd   (ram_cmd),
    .ram_state (ram_state),
    .ram_load  (ram_load)
  );

endmodule

/* design/ram_model.sv */
// fixed-latency word RAM; needs MEM_RAM_LAT >= 2, upper address bits are ignored
`timescale 1ns/1ns
`include "mem_defs.svh"

module ram_model
  import ram_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  ram_cmd_t               ram_cmd,
  output ram_state_t             ram_state,
  output logic [`MEM_WORD_W-1:0] ram_load
);

  localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
  localparam int CNT_W = $clog2(`MEM_RAM_LAT);

  logic [`MEM_WORD_W-1:0] mem [`MEM_RAM_WORDS];
  logic [CNT_W-1:0]       cnt;  // busy cycles left
  logic [IDX_W-1:0]       idx;

  assign idx = ram_cmd.addr[IDX_W-1:0];  // wraps at depth

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      ram_state <= FREE;
      cnt       <= '0;
      for (int i = 0; i < `MEM_RAM_WORDS; i++)
        mem[i] <= '0;
    end
    else
    begin
      case (ram_state)
        FREE:
        begin
          if (ram_cmd.ren || ram_cmd.wen)
          begin
            ram_state <= BUSY;
            cnt       <= CNT_W'(`MEM_RAM_LAT - 2);
          end
        end
        BUSY:
        begin
          if (cnt == '0)
            ram_state <= ACCESS;
          else
            cnt <= cnt - 1'b1;
        end
        ACCESS:
        begin
          if (ram_cmd.wen)
            mem[idx] <= ram_cmd.store;  // commit
          ram_state <= FREE;
        end
        default: ram_state <= FREE;
      endcase
    end
  end

  // only meaningful in ACCESS
  assign ram_load = (ram_state == ACCESS) ? mem[idx] : '0;

endmodule

/* design/ram_pkg.sv */
// RAM side of the controller; no ERROR state, a command is one word
`include "mem_defs.svh"

package ram_pkg;

  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS  // write commits, read data valid
  } ram_state_t;

  // held by the controller until ACCESS
  typedef struct packed {
    logic                   ren;
    logic                   wen;
    logic [`MEM_WORD_W-1:0] addr;
    logic [`MEM_WORD_W-1:0] store;
  } ram_cmd_t;

endpackage

/* include/mem_defs.svh */
// sizes for the two-cpu memory side; the controller assumes exactly two cpus and RAM_LAT >= 2
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define MEM_WORD_W 32

// processors sharing the RAM
`define MEM_CPUS 2

// word addresses wrap at this depth
`define MEM_RAM_WORDS 256

// cycles from a command seen in FREE to the ACCESS cycle
`define MEM_RAM_LAT 3

`endif

/* sim/mem_assert.sv */
// protocol assertions bound into the memory top; written for two cpus, RAM latency itself unchecked
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_assert
  import bus_pkg::*;
  import ram_pkg::*;
(
  input logic       CLK,
  input logic       nRST,
  input cpu_req_t   req [`MEM_CPUS],
  input port_pend_t pend [`MEM_CPUS],
  input cpu_rsp_t   rsp [`MEM_CPUS],
  input ram_cmd_t   ram_cmd,
  input ram_state_t ram_state
);

  generate
    for (genvar c = 0; c < `MEM_CPUS; c++)
    begin : g_cpu
      // a cache waits for its response before the next strobe of the same kind
      a_ifetch_full: assert property (@(posedge CLK) disable iff (!nRST)
        (req[c].valid && req[c].kind == IFETCH) |-> !pend[c].ivalid)
        else $error("fetch strobe on cpu %0d while its fetch slot is full", c);

      a_data_full: assert property (@(posedge CLK) disable iff (!nRST)
        (req[c].valid && req[c].kind inside {DREAD, DREADX, DWRITE}) |-> !pend[c].dvalid)
        else $error("data strobe on cpu %0d while its data slot is full", c);

      a_rsp_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        rsp[c].valid |=> !rsp[c].valid)
        else $error("response to cpu %0d held longer than one cycle", c);
    end
  endgenerate

  a_cmd_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (ram_state == BUSY) |-> $stable(ram_cmd))
    else $error("RAM command changed while the RAM was busy");

endmodule

/* sim/mem_checker.sv */
// reference model of arbitration and memory contents; expects caches to keep the one-request rule
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_checker
  import bus_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  cpu_req_t         req [`MEM_CPUS],
  input  snoop_rsp_t       snoop_rsp [`MEM_CPUS],
  input  cpu_rsp_t         rsp [`MEM_CPUS],
  input  snoop_t           snoop [`MEM_CPUS],
  input  logic [8*16-1:0]  test_name,
  input  logic             test_end,
  output int               checks,
  output int               errs
);

  localparam int IDX_W = $clog2(`MEM_RAM_WORDS);

  logic [`MEM_WORD_W-1:0] shadow [`MEM_RAM_WORDS];
  cpu_req_t               islot [`MEM_CPUS];  // mirror of the port slots
  cpu_req_t               dslot [`MEM_CPUS];
  cpu_req_t               cur;
  logic                   busy;
  logic                   who;    // cpu in service
  logic                   who_i;  // service is a fetch
  logic                   lru;
  int                     t_checks;
  int                     t_errs;

  // word the response must carry; a write answers zero
  function automatic logic [`MEM_WORD_W-1:0] ref_data(cpu_req_t r);
    if (r.kind == DWRITE)
      return '0;
    return shadow[r.addr[IDX_W-1:0]];
  endfunction

  task automatic compare(string what, logic [`MEM_WORD_W-1:0] expv,
                         logic [`MEM_WORD_W-1:0] actv);
    t_checks++;
    if (expv !== actv)
    begin
      t_errs++;
      $display("CHECK FAILED %0s %0s: expected %h, actual %h", test_name, what, expv, actv);
    end
  endtask

  task automatic complain(string msg);
    t_errs++;
    $display("%0s: %0s", test_name, msg);
  endtask

  // sampled mid-cycle, away from the edges
  always @(negedge CLK)
  begin
    if (!nRST)
    begin
      busy     = 1'b0;
      lru      = 1'b0;
      t_checks = 0;
      t_errs   = 0;
      checks   = 0;
      errs     = 0;
      for (int c = 0; c < `MEM_CPUS; c++)
      begin
        islot[c] = '0;
        dslot[c] = '0;
      end
      for (int i = 0; i < `MEM_RAM_WORDS; i++)
        shadow[i] = '0;
    end
    else
    begin
      if (!busy)
      begin
        t_checks++;
        if (rsp[0].valid || rsp[1].valid || snoop[0].valid || snoop[1].valid)
          complain("response or snoop while no request is in service");
        // fixed priority for data, LRU between fetches
        if (dslot[0].valid || dslot[1].valid)
        begin
          busy  = 1'b1;
          who_i = 1'b0;
          who   = !dslot[0].valid;
        end
        else if (islot[0].valid || islot[1].valid)
        begin
          busy  = 1'b1;
          who_i = 1'b1;
          who   = (islot[0].valid && islot[1].valid) ? lru : islot[1].valid;
          lru   = ~who;
        end
      end
      else
      begin
        if (!who_i && snoop_rsp[~who].valid && snoop_rsp[~who].dirty)
          shadow[dslot[who].addr[IDX_W-1:0]] = snoop_rsp[~who].data;  // written back
        for (int c = 0; c < `MEM_CPUS; c++)
        begin
          if (snoop[c].valid)
          begin
            if (who_i || dslot[who].kind == DWRITE || c == int'(who))
              complain($sformatf("snoop to cpu %0d with no read of the other cpu", c));
            else
            begin
              compare("snoop addr", dslot[who].addr, snoop[c].addr);
              compare("snoop inv", 32'(dslot[who].kind == DREADX), 32'(snoop[c].inv));
            end
          end
          if (rsp[c].valid)
          begin
            compare("responding cpu", 32'(who), c);
            compare("fetch flag", 32'(who_i), 32'(rsp[c].is_instr));
            cur = who_i ? islot[who] : dslot[who];
            compare("response data", ref_data(cur), rsp[c].data);
            if (cur.kind == DWRITE)
              shadow[cur.addr[IDX_W-1:0]] = cur.data;
            if (who_i)
              islot[who] = '0;
            else
              dslot[who] = '0;
            busy = 1'b0;
          end
        end
      end
      for (int c = 0; c < `MEM_CPUS; c++)
      begin
        if (req[c].valid && req[c].kind == IFETCH && !islot[c].valid)
          islot[c] = req[c];
        else if (req[c].valid && req[c].kind inside {DREAD, DREADX, DWRITE} && !dslot[c].valid)
          dslot[c] = req[c];
      end
      if (test_end)
      begin
        $display("%0s: %0d checks, %0d errors", test_name, t_checks, t_errs);
        checks   = checks + t_checks;
        errs     = errs + t_errs;
        t_checks = 0;
        t_errs   = 0;
      end
    end
  end

endmodule

/* sim/tb_mem_subsys.sv */
// two caches played by the testbench; each answers snoops from a 4-entry dirty table
`timescale 1ns/1ns
`include "mem_defs.svh"

module tb_mem_subsys
  import bus_pkg::*;
();

  localparam int N_REQ = 17;
  localparam int LIMIT = 40 * N_REQ + 200;  // cycles

  logic                   CLK;
  logic                   nRST;
  cpu_req_t               req [`MEM_CPUS];
  snoop_rsp_t             snoop_rsp [`MEM_CPUS];
  cpu_rsp_t               rsp [`MEM_CPUS];
  snoop_t                 snoop [`MEM_CPUS];
  logic [8*16-1:0]        test_name;
  logic                   test_end;
  int                     checks;
  int                     errs;
  int                     rsp_total = 0;
  int                     cycles = 0;
  integer                 seed;
  int                     wait_cnt [`MEM_CPUS];  // cycles to the snoop answer
  logic [`MEM_WORD_W-1:0] wait_addr [`MEM_CPUS];
  logic                   dirty_v [`MEM_CPUS][4];
  logic [`MEM_WORD_W-1:0] dirty_a [`MEM_CPUS][4];
  logic [`MEM_WORD_W-1:0] dirty_d [`MEM_CPUS][4];

  mem_subsys_top u_mem_subsys_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .snoop_rsp (snoop_rsp),
    .rsp       (rsp),
    .snoop     (snoop)
  );

  mem_checker u_mem_checker (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .snoop_rsp (snoop_rsp),
    .rsp       (rsp),
    .snoop     (snoop),
    .test_name (test_name),
    .test_end  (test_end),
    .checks    (checks),
    .errs      (errs)
  );

  bind mem_subsys_top mem_assert u_mem_assert (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .pend      (pend),
    .rsp       (rsp),
    .ram_cmd   (ram_cmd),
    .ram_state (ram_state)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  always @(negedge CLK)
  begin
    for (int c = 0; c < `MEM_CPUS; c++)
      if (rsp[c].valid)
        rsp_total++;
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("run stopped after %0d cycles with %0d of %0d responses", LIMIT, rsp_total,
               N_REQ);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic answer(int c);
    snoop_rsp[c].valid = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      if (dirty_v[c][i] && dirty_a[c][i] == wait_addr[c])
      begin
        snoop_rsp[c].dirty = 1'b1;
        snoop_rsp[c].data  = dirty_d[c][i];
        dirty_v[c][i]      = 1'b0;  // line clean or gone now
      end
    end
  endtask

  // snoop responders, 2 to 5 cycles late
  always @(posedge CLK)
  begin
    #1;
    for (int c = 0; c < `MEM_CPUS; c++)
    begin
      snoop_rsp[c] = '0;
      if (wait_cnt[c] > 0)
      begin
        wait_cnt[c]--;
        if (wait_cnt[c] == 0)
          answer(c);
      end
      if (snoop[c].valid)
      begin
        wait_cnt[c]  = 2 + ($unsigned($random(seed)) % 4);
        wait_addr[c] = snoop[c].addr;
      end
    end
  end

  task automatic set_dirty(int c, int i, logic [`MEM_WORD_W-1:0] a,
                           logic [`MEM_WORD_W-1:0] d);
    dirty_v[c][i] = 1'b1;
    dirty_a[c][i] = a;
    dirty_d[c][i] = d;
  endtask

  task automatic drive(int c, req_kind_t k, logic [`MEM_WORD_W-1:0] a,
                       logic [`MEM_WORD_W-1:0] d);
    req[c] = '{valid: 1'b1, kind: k, addr: a, data: d};
  endtask

  // strobes last one cycle
  task automatic pulse();
    @(posedge CLK);
    #1;
    req[0] = '0;
    req[1] = '0;
  endtask

  task automatic wait_rsp(int target);
    while (rsp_total < target)
    begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic end_test();
    test_end = 1'b1;
    @(posedge CLK);
    #1;
    test_end = 1'b0;
  endtask

  initial
  begin
    seed      = 32'hf81c;
    nRST      = 1'b0;
    test_end  = 1'b0;
    test_name = "reset";
    for (int c = 0; c < `MEM_CPUS; c++)
    begin
      req[c]       = '0;
      snoop_rsp[c] = '0;
      wait_cnt[c]  = 0;
      wait_addr[c] = '0;
      for (int i = 0; i < 4; i++)
        dirty_v[c][i] = 1'b0;
    end
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;

    test_name = "reset_idle";
    repeat (8) @(posedge CLK);
    #1;
    end_test();

    test_name = "wb_then_read";
    drive(0, DWRITE, 32'h10, 32'ha5a5_0010);
    pulse();
    wait_rsp(1);
    drive(1, DREAD, 32'h10, '0);
    pulse();
    wait_rsp(2);
    end_test();

    test_name = "dirty_snoop";
    set_dirty(0, 0, 32'h20, 32'h1234_5678);
    drive(1, DREAD, 32'h20, '0);
    pulse();
    wait_rsp(3);
    drive(1, DREAD, 32'h20, '0);  // now clean, from RAM
    pulse();
    wait_rsp(4);
    end_test();

    test_name = "snoop_inv";
    set_dirty(1, 0, 32'h30, 32'h0bad_0030);
    drive(0, DREADX, 32'h30, '0);
    pulse();
    wait_rsp(5);
    drive(1, DREAD, 32'h31, '0);
    pulse();
    wait_rsp(6);
    end_test();

    test_name = "ifetch_lru";
    drive(0, IFETCH, 32'h10, '0);
    drive(1, IFETCH, 32'h20, '0);
    pulse();
    wait_rsp(8);
    // cpu 0 served last, so cpu 1 is owed the next tie
    drive(0, IFETCH, 32'h30, '0);
    pulse();
    wait_rsp(9);
    drive(0, IFETCH, 32'h20, '0);
    drive(1, IFETCH, 32'h110, '0);  // wraps onto 0x10
    pulse();
    wait_rsp(11);
    end_test();

    test_name = "priority";
    drive(0, DWRITE, 32'h40, 32'hc0de_0040);
    drive(1, DWRITE, 32'h48, 32'hc0de_0048);
    pulse();
    drive(0, IFETCH, 32'h40, '0);
    drive(1, IFETCH, 32'h48, '0);
    pulse();
    wait_rsp(15);
    drive(0, DREAD, 32'h48, '0);
    drive(1, DWRITE, 32'h40, 32'h5eed_0040);
    pulse();
    wait_rsp(17);
    end_test();

    $display("%0d checks, %0d errors", checks, errs);
    if (errs == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
design/bus_pkg.sv
design/ram_pkg.sv
design/cpu_port.sv
design/coherence_ctrl.sv
design/ram_model.sv
design/mem_subsys_top.sv
sim/mem_assert.sv
sim/mem_checker.sv
sim/tb_mem_subsys.sv
